/* phold_sched.f */
design/event_pkg.sv
design/sched_pkg.sv
design/rr_arbiter.sv
design/event_intake.sv
design/event_queue.sv
design/sim_control.sv
design/event_dispatch.sv
design/phold_sched.sv
tests/tb_clock.sv
tests/tb_phold_sched.sv

/* Bender.yml */
package:
  name: phold_sched

sources:
  - design/event_pkg.sv
  - design/sched_pkg.sv
  - design/rr_arbiter.sv
  - design/event_intake.sv
  - design/event_queue.sv
  - design/sim_control.sv
  - design/event_dispatch.sv
  - design/phold_sched.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_phold_sched.sv

/* tests/tb_phold_sched.sv */
`timescale 1ns/10ps

module tb_phold_sched;

   import event_pkg::*;
   import sched_pkg::*;

   localparam int          NC         = 4;
   localparam int          DEPTH      = 16;
   localparam int          NIE        = 8;
   localparam int          END_TIME   = 400;
   localparam logic [15:0] SEED16     = 16'hffff;
   localparam int          PEND_MAX   = 4;
   // about 25 hops per lineage at ~16 ts each, a few cycles per hop, with wide margin
   localparam int          MAX_CYCLES = 4000;

   logic                clk;
   logic                rst_n;
   logic [NC-1:0]       core_new_vld;
   event_msg_t          core_new_event [NC];
   logic [NC-1:0]       core_new_ack;
   logic [NC-1:0]       core_ready;
   logic [TIME_WID-1:0] min_time;
   logic                min_time_vld;
   logic [NC-1:0]       dispatch_vld;
   event_msg_t          dispatch_event;
   logic [7:0]          dispatch_rnd;
   logic [TIME_WID-1:0] gvt;
   logic                rtn_vld;

   sim_state_e          st_m;       // model of the control FSM
   int                  init_cnt;
   event_msg_t          mq [$];     // model queue, kept sorted
   int                  in_ptr;
   int                  out_ptr;
   logic [15:0]         lfsr_m;
   logic [TIME_WID-1:0] gvt_m;
   logic                rtn_m;

   event_msg_t          pend [NC][PEND_MAX];  // events each core still has to send
   int                  pend_cnt [NC];
   logic [NC-1:0]       acked;
   logic [NC-1:0]       got_vld;
   event_msg_t          got_msg;
   logic [7:0]          got_rnd;
   integer              seed;
   int                  cycle;
   logic                done;

   tb_clock #(.PERIOD(40)) i_tb_clock (.clk(clk));

   phold_sched #(
      .NUM_CORE        (NC),
      .QUEUE_DEPTH     (DEPTH),
      .NUM_INIT_EVENTS (NIE),
      .SIM_END_TIME    (END_TIME),
      .LFSR_SEED       (SEED16)
   ) i_phold_sched (
      .clk            (clk),
      .rst_n          (rst_n),
      .core_new_vld   (core_new_vld),
      .core_new_event (core_new_event),
      .core_new_ack   (core_new_ack),
      .core_ready     (core_ready),
      .min_time       (min_time),
      .min_time_vld   (min_time_vld),
      .dispatch_vld   (dispatch_vld),
      .dispatch_event (dispatch_event),
      .dispatch_rnd   (dispatch_rnd),
      .gvt            (gvt),
      .rtn_vld        (rtn_vld)
   );

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic draw_below(input int n, output int v);
      v = $unsigned($random(seed)) % n;
   endtask

   function automatic logic is_null(input event_msg_t m);
      return m.cancel && (m.lp_id == '0) && (m.ts == '0);
   endfunction

   // first request at or after ptr, -1 if none
   task automatic pick_first(input logic [NC-1:0] req, input int ptr, output int idx);
      idx = -1;
      for (int i = 0; i < NC; i++) begin
         if (idx < 0 && req[(ptr + i) % NC]) begin
            idx = (ptr + i) % NC;
         end
      end
   endtask

   // behind every entry with key <= new key, cancels ahead at equal ts
   task automatic insert_sorted(input event_msg_t m);
      int pos;
      pos = mq.size();
      for (int i = mq.size() - 1; i >= 0; i--) begin
         if ({mq[i].ts, ~mq[i].cancel} > {m.ts, ~m.cancel}) begin
            pos = i;
         end
      end
      mq.insert(pos, m);
   endtask

   task automatic add_core_event(input int c, input logic [TIME_WID-1:0] ts);
      int         r;
      event_msg_t m;
      draw_below(8, r);
      m.cancel = (r == 0);  // roughly one in eight
      draw_below(8, r);
      m.lp_id = NB_LPID'(r);
      m.ts    = ts;
      pend[c][pend_cnt[c]] = m;
      pend_cnt[c]++;
   endtask

   // one rising edge of the reference model, compared before it moves on
   task automatic step_model();
      logic [NC-1:0]       exp_ack;
      logic [NC-1:0]       exp_disp;
      int                  gi;
      int                  di;
      logic [TIME_WID-1:0] g_next;
      exp_ack  = '0;
      exp_disp = '0;
      gi = -1;
      di = -1;
      if (st_m == st_running && mq.size() < DEPTH) begin
         pick_first(core_new_vld, in_ptr, gi);
      end
      if (gi >= 0) begin
         exp_ack[gi] = 1'b1;
      end
      if (st_m == st_running && gi < 0 && mq.size() > 0) begin
         pick_first(core_ready, out_ptr, di);  // intake wins the cycle
      end
      if (di >= 0) begin
         exp_disp[di] = 1'b1;
      end
      check_value("core_new_ack", core_new_ack, exp_ack);
      check_value("dispatch_vld", dispatch_vld, exp_disp);
      check_value("gvt", gvt, gvt_m);
      check_value("rtn_vld", rtn_vld, rtn_m);
      if (di >= 0) begin
         check_value("dispatch_event", dispatch_event, mq[0]);
         check_value("dispatch_rnd", dispatch_rnd, lfsr_m[7:0]);
         got_msg = mq[0];
         got_rnd = lfsr_m[7:0];
      end
      acked   = exp_ack;
      got_vld = exp_disp;

      g_next = gvt_m;
      if (min_time_vld && mq.size() > 0) begin
         g_next = (min_time < mq[0].ts) ? min_time : mq[0].ts;
      end else if (min_time_vld) begin
         g_next = min_time;
      end else if (mq.size() > 0) begin
         g_next = mq[0].ts;
      end
      rtn_m = (st_m == st_running) && (gvt_m > END_TIME);
      if (st_m == st_running) begin
         gvt_m = g_next;
      end

      if (st_m == st_init && mq.size() < DEPTH) begin
         insert_sorted('{cancel: 1'b0, lp_id: NB_LPID'(init_cnt), ts: '0});
      end
      if (gi >= 0 && !is_null(core_new_event[gi])) begin
         insert_sorted(core_new_event[gi]);
      end
      if (di >= 0) begin
         void'(mq.pop_front());
         out_ptr = (di + 1) % NC;
      end
      if (gi >= 0) begin
         in_ptr = (gi + 1) % NC;
      end
      if (st_m == st_init || di >= 0) begin
         lfsr_m = {lfsr_m[14:0], lfsr_m[15] ^ lfsr_m[13] ^ lfsr_m[12] ^ lfsr_m[10]};
      end

      case (st_m)
         st_idle: begin
            st_m     = st_init;
            init_cnt = 0;
         end
         st_init: begin
            if (init_cnt == NIE - 1) begin
               st_m = st_ready;
            end
            init_cnt++;
         end
         st_ready:   st_m = st_running;
         st_running: if (rtn_m) st_m = st_finished;
         default:    st_m = st_idle;
      endcase
   endtask

   // core side, runs on the falling edge
   task automatic update_cores();
      int                  total;
      int                  r;
      logic [TIME_WID-1:0] lo;
      logic                any;
      total = mq.size();
      for (int c = 0; c < NC; c++) begin
         total += pend_cnt[c];
      end
      for (int c = 0; c < NC; c++) begin
         if (acked[c]) begin
            for (int k = 0; k < PEND_MAX - 1; k++) begin
               pend[c][k] = pend[c][k + 1];
            end
            pend_cnt[c]--;
         end
         if (got_vld[c]) begin
            draw_below(8, r);
            if (r == 0) begin
               pend[c][pend_cnt[c]] = '{cancel: 1'b1, lp_id: '0, ts: '0};  // null first
               pend_cnt[c]++;
            end
            add_core_event(c, got_msg.ts + 1 + (got_rnd % 32));
            draw_below(4, r);
            if (total < DEPTH + 2 && r == 0) begin
               draw_below(32, r);
               add_core_event(c, got_msg.ts + 1 + r);  // fan out, lets the queue fill
            end
         end
         core_new_vld[c] = (pend_cnt[c] > 0);
         if (pend_cnt[c] > 0) begin
            core_new_event[c] = pend[c][0];
         end else begin
            core_new_event[c] = '0;
         end
         draw_below(2, r);
         core_ready[c] = (pend_cnt[c] < 2) && (r == 1);
      end
      any = 1'b0;
      lo  = '0;
      for (int c = 0; c < NC; c++) begin
         for (int k = 0; k < pend_cnt[c]; k++) begin
            if (!is_null(pend[c][k]) && (!any || pend[c][k].ts < lo)) begin
               lo  = pend[c][k].ts;
               any = 1'b1;
            end
         end
      end
      min_time     = lo;
      min_time_vld = any;
   endtask

   initial begin
      seed         = 5;
      cycle        = 0;
      done         = 1'b0;
      rst_n        = 1'b0;
      core_new_vld = '0;
      core_ready   = '0;
      min_time     = '0;
      min_time_vld = 1'b0;
      for (int c = 0; c < NC; c++) begin
         core_new_event[c] = '0;
         pend_cnt[c]       = 0;
      end
      st_m     = st_idle;
      init_cnt = 0;
      in_ptr   = 0;
      out_ptr  = 0;
      lfsr_m   = SEED16;
      gvt_m    = '0;
      rtn_m    = 1'b0;
      acked    = '0;
      got_vld  = '0;
      got_msg  = '0;
      got_rnd  = '0;

      // reset values, looked at mid-cycle
      repeat (8) begin
         @(negedge clk);
         check_value("dispatch_vld", dispatch_vld, '0);
         check_value("core_new_ack", core_new_ack, '0);
         check_value("rtn_vld", rtn_vld, '0);
         check_value("gvt", gvt, '0);
      end
      rst_n = 1'b1;

      while (!done) begin
         @(posedge clk);
         done = rtn_m;  // the pulse itself is checked in this step
         step_model();
         cycle++;
         if (cycle >= MAX_CYCLES) begin
            $display("timeout: no return pulse within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation did not finish");
         end
         @(negedge clk);
         update_cores();
      end

      // one more edge, the return pulse has to be gone
      @(posedge clk);
      step_model();

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD = 40  // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD / 2) clk = ~clk;

endmodule

/* design/phold_sched.sv */
`timescale 1ns/10ps

module phold_sched #(
   parameter int          NUM_CORE        = 4,
   parameter int          QUEUE_DEPTH     = 16,
   parameter int          NUM_INIT_EVENTS = 8,   // at most 2**NB_LPID
   parameter int          SIM_END_TIME    = 400,
   parameter logic [15:0] LFSR_SEED       = 16'hffff
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [NUM_CORE-1:0]            core_new_vld,
   input  event_pkg::event_msg_t          core_new_event [NUM_CORE],
   output logic [NUM_CORE-1:0]            core_new_ack,
   input  logic [NUM_CORE-1:0]            core_ready,
   input  logic [event_pkg::TIME_WID-1:0] min_time,
   input  logic                           min_time_vld,
   output logic [NUM_CORE-1:0]            dispatch_vld,
   output event_pkg::event_msg_t          dispatch_event,
   output logic [7:0]                     dispatch_rnd,
   output logic [event_pkg::TIME_WID-1:0] gvt,
   output logic                           rtn_vld
);

   import event_pkg::*;
   import sched_pkg::*;

   sim_state_e         sim_state;
   logic [NB_LPID-1:0] init_lp;
   logic               enq;
   logic               deq;
   logic               intake_busy;
   queue_key_t         enq_key;
   queue_key_t         head_key;
   logic               q_empty;
   logic               q_full;

   // an acked null also holds off dispatch that cycle
   assign intake_busy = enq || (|core_new_ack);

   event_intake #(
      .NUM_CORE        (NUM_CORE),
      .NUM_INIT_EVENTS (NUM_INIT_EVENTS)
   ) i_event_intake (
      .clk            (clk),
      .rst_n          (rst_n),
      .sim_state      (sim_state),
      .init_lp        (init_lp),
      .core_new_vld   (core_new_vld),
      .core_new_event (core_new_event),
      .q_full         (q_full),
      .core_new_ack   (core_new_ack),
      .enq            (enq),
      .enq_key        (enq_key)
   );

   event_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_event_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .enq_key  (enq_key),
      .deq      (deq),
      .head_key (head_key),
      .q_empty  (q_empty),
      .q_full   (q_full)
   );

   sim_control #(
      .NUM_INIT_EVENTS (NUM_INIT_EVENTS),
      .SIM_END_TIME    (SIM_END_TIME)
   ) i_sim_control (
      .clk          (clk),
      .rst_n        (rst_n),
      .head_key     (head_key),
      .q_empty      (q_empty),
      .min_time     (min_time),
      .min_time_vld (min_time_vld),
      .sim_state    (sim_state),
      .init_lp      (init_lp),
      .gvt          (gvt),
      .rtn_vld      (rtn_vld)
   );

   event_dispatch #(
      .NUM_CORE  (NUM_CORE),
      .LFSR_SEED (LFSR_SEED)
   ) i_event_dispatch (
      .clk            (clk),
      .rst_n          (rst_n),
      .sim_state      (sim_state),
      .enq            (intake_busy),
      .q_empty        (q_empty),
      .head_key       (head_key),
      .core_ready     (core_ready),
      .deq            (deq),
      .dispatch_vld   (dispatch_vld),
      .dispatch_event (dispatch_event),
      .dispatch_rnd   (dispatch_rnd)
   );

endmodule

/* design/event_dispatch.sv */
`timescale 1ns/10ps

module event_dispatch #(
   parameter int          NUM_CORE  = 4,
   parameter logic [15:0] LFSR_SEED = 16'hffff
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  sched_pkg::sim_state_e sim_state,
   input  logic                  enq,
   input  logic                  q_empty,
   input  event_pkg::queue_key_t head_key,
   input  logic [NUM_CORE-1:0]   core_ready,
   output logic                  deq,
   output logic [NUM_CORE-1:0]   dispatch_vld,
   output event_pkg::event_msg_t dispatch_event,
   output logic [7:0]            dispatch_rnd
);

   import event_pkg::*;
   import sched_pkg::*;

   logic                core_avail;
   logic [NUM_CORE-1:0] grant_onehot;
   logic [15:0]         lfsr_q;
   logic                lfsr_step;

   rr_arbiter #(
      .NR (NUM_CORE)
   ) dispatch_arb (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (core_ready),
      .advance      (deq),
      .grant_vld    (core_avail),
      .grant_idx    (),
      .grant_onehot (grant_onehot)
   );

   // only when intake is quiet
   assign deq = (sim_state == st_running) && !enq && !q_empty && core_avail;

   assign dispatch_vld   = deq ? grant_onehot : '0;
   assign dispatch_event = '{cancel: ~head_key.pri, lp_id: head_key.lp_id, ts: head_key.ts};
   assign dispatch_rnd   = lfsr_q[7:0];  // value before the step

   assign lfsr_step = deq || (sim_state == st_init);

   // fibonacci form, feedback into bit 0
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr_q <= LFSR_SEED;
      end else if (lfsr_step) begin
         lfsr_q <= {lfsr_q[14:0], ^(lfsr_q & LFSR_TAPS)};
      end
   end

endmodule

/* design/sim_control.sv */
`timescale 1ns/10ps

module sim_control #(
   parameter int NUM_INIT_EVENTS = 8,
   parameter int SIM_END_TIME    = 400
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  event_pkg::queue_key_t          head_key,
   input  logic                           q_empty,
   input  logic [event_pkg::TIME_WID-1:0] min_time,
   input  logic                           min_time_vld,
   output sched_pkg::sim_state_e          sim_state,
   output logic [event_pkg::NB_LPID-1:0]  init_lp,
   output logic [event_pkg::TIME_WID-1:0] gvt,
   output logic                           rtn_vld
);

   import event_pkg::*;
   import sched_pkg::*;

   sim_state_e          state_d;
   logic                sim_done;
   logic                init_last;
   logic [TIME_WID-1:0] gvt_d;

   assign init_last = (init_lp == NB_LPID'(NUM_INIT_EVENTS - 1));
   assign sim_done  = (sim_state == st_running) && (gvt > TIME_WID'(SIM_END_TIME));

   always_comb begin
      state_d = sim_state;
      case (sim_state)
         st_idle:     state_d = st_init;
         st_init:     if (init_last) state_d = st_ready;
         st_ready:    state_d = st_running;
         st_running:  if (sim_done) state_d = st_finished;
         st_finished: state_d = st_idle;
         default:     state_d = st_idle;
      endcase
   end

   // min of in-flight time and queue head, whichever exist
   always_comb begin
      gvt_d = gvt;
      if (min_time_vld && !q_empty) begin
         gvt_d = (min_time < head_key.ts) ? min_time : head_key.ts;
      end else if (min_time_vld) begin
         gvt_d = min_time;
      end else if (!q_empty) begin
         gvt_d = head_key.ts;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sim_state <= st_idle;
         init_lp   <= '0;
         gvt       <= '0;
         rtn_vld   <= 1'b0;
      end else begin
         sim_state <= state_d;
         init_lp   <= (sim_state == st_init) ? init_lp + 1'b1 : '0;
         rtn_vld   <= sim_done;  // high only while in st_finished
         if (sim_state == st_running) begin
            gvt <= gvt_d;
         end
      end
   end

endmodule

/* design/event_queue.sv */
`timescale 1ns/10ps

module event_queue #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enq,
   input  event_pkg::queue_key_t enq_key,
   input  logic                  deq,
   output event_pkg::queue_key_t head_key,
   output logic                  q_empty,
   output logic                  q_full
);

   import event_pkg::*;

   localparam int CW = $clog2(QUEUE_DEPTH + 1);

   queue_key_t             entry_q [QUEUE_DEPTH];  // entry 0 is the head
   logic [CW-1:0]          count_q;
   logic [QUEUE_DEPTH-1:0] le;       // valid entry sorts at or before the new key
   logic [QUEUE_DEPTH-1:0] ins_at;   // new key lands here
   logic                   do_enq;
   logic                   do_deq;

   function automatic logic [TIME_WID:0] sort_val(input queue_key_t k);
      return {k.ts, k.pri};
   endfunction

   assign q_empty = (count_q == '0);
   assign q_full  = (count_q == CW'(QUEUE_DEPTH));
   assign do_enq  = enq && !q_full;
   assign do_deq  = deq && !q_empty && !do_enq;  // intake side wins

   // le is a prefix since the array stays sorted
   always_comb begin
      logic prev;
      prev = 1'b1;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         le[i]     = (CW'(i) < count_q) && (sort_val(entry_q[i]) <= sort_val(enq_key));
         ins_at[i] = !le[i] && prev;
         prev      = le[i];
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (do_enq) begin
            if (ins_at[i]) begin
               entry_q[i] <= enq_key;
            end else if (!le[i]) begin
               entry_q[i] <= entry_q[(i > 0) ? i - 1 : 0];  // make room
            end
         end else if (do_deq) begin
            entry_q[i] <= entry_q[(i < QUEUE_DEPTH - 1) ? i + 1 : i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (do_enq) begin
         count_q <= count_q + 1'b1;
      end else if (do_deq) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign head_key = entry_q[0];

endmodule

/* design/event_intake.sv */
`timescale 1ns/10ps

module event_intake #(
   parameter int NUM_CORE        = 4,
   parameter int NUM_INIT_EVENTS = 8
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  sched_pkg::sim_state_e         sim_state,
   input  logic [event_pkg::NB_LPID-1:0] init_lp,
   input  logic [NUM_CORE-1:0]           core_new_vld,
   input  event_pkg::event_msg_t         core_new_event [NUM_CORE],
   input  logic                          q_full,
   output logic [NUM_CORE-1:0]           core_new_ack,
   output logic                          enq,
   output event_pkg::queue_key_t         enq_key
);

   import event_pkg::*;
   import sched_pkg::*;

   localparam int IW = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

   logic                grant_vld;
   logic [IW-1:0]       grant_idx;
   logic [NUM_CORE-1:0] grant_onehot;
   logic                seeding;
   logic                take;      // a core's event is accepted
   logic                is_null;
   event_msg_t          new_msg;

   assign seeding = (sim_state == st_init) && (int'(init_lp) < NUM_INIT_EVENTS);
   assign take    = (sim_state == st_running) && grant_vld && !q_full;

   rr_arbiter #(
      .NR (NUM_CORE)
   ) intake_arb (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (core_new_vld),
      .advance      (take),
      .grant_vld    (grant_vld),
      .grant_idx    (grant_idx),
      .grant_onehot (grant_onehot)
   );

   always_comb begin
      if (sim_state == st_init) begin
         // seed event, one per lp at time zero
         new_msg = '{cancel: 1'b0, lp_id: init_lp, ts: '0};
      end else begin
         new_msg = core_new_event[grant_idx];
      end
   end

   assign is_null = (new_msg == NULL_MSG);

   // nulls still get their ack, they just never reach the queue
   assign core_new_ack = take ? grant_onehot : '0;
   assign enq          = seeding || (take && !is_null);

   assign enq_key = '{ts: new_msg.ts, pri: ~new_msg.cancel, lp_id: new_msg.lp_id};

endmodule

/* design/rr_arbiter.sv */
`timescale 1ns/10ps

module rr_arbiter #(
   parameter  int NR = 4,
   localparam int IW = (NR > 1) ? $clog2(NR) : 1
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [NR-1:0] req,
   input  logic          advance,     // grant taken this cycle
   output logic          grant_vld,
   output logic [IW-1:0] grant_idx,
   output logic [NR-1:0] grant_onehot
);

   logic [IW-1:0] ptr_q;  // first index to look at

   // first request at or after the pointer, wrapping
   always_comb begin
      int unsigned cand;
      grant_vld = 1'b0;
      grant_idx = '0;
      for (int i = 0; i < NR; i++) begin
         cand = (int'(ptr_q) + i) % NR;
         if (!grant_vld && req[cand]) begin
            grant_vld = 1'b1;
            grant_idx = IW'(cand);
         end
      end
   end

   assign grant_onehot = grant_vld ? (NR'(1) << grant_idx) : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr_q <= '0;
      end else if (advance && grant_vld) begin
         // move just past the grantee
         ptr_q <= (int'(grant_idx) == NR - 1) ? '0 : grant_idx + 1'b1;
      end
   end

endmodule

/* design/sched_pkg.sv */
package sched_pkg;

   // scheduler control states
   typedef enum logic [2:0] {
      st_idle,
      st_init,
      st_ready,
      st_running,
      st_finished
   } sim_state_e;

   // x^16 + x^14 + x^13 + x^11 + 1, bits 15 13 12 10
   localparam logic [15:0] LFSR_TAPS = 16'hb400;

endpackage

/* design/event_pkg.sv */
package event_pkg;

   localparam int TIME_WID = 16;  // timestamp width
   localparam int NB_LPID  = 3;   // logical process id width

   // message as it travels between scheduler and cores
   typedef struct packed {
      logic                cancel;  // anti message
      logic [NB_LPID-1:0]  lp_id;
      logic [TIME_WID-1:0] ts;
   } event_msg_t;

   // cancel with zero target and time carries no event
   localparam event_msg_t NULL_MSG = '{cancel: 1'b1, lp_id: '0, ts: '0};

   // queue entry, {ts, pri} is the sort field and lp_id rides along below it
   typedef struct packed {
      logic [TIME_WID-1:0] ts;
      logic                pri;    // inverted cancel, so anti messages sort first
      logic [NB_LPID-1:0]  lp_id;
   } queue_key_t;

endpackage
